// File: axil_mmio_bridge.sv
// AXI4-Lite slave bridging single transactions onto the internal register bus
`timescale 1ns/1ns
`default_nettype none

module axil_mmio_bridge (
    input  logic                      I_CLOCK,
    input  logic                      I_RESET,
    input  gb_timer_pkg::mmio_addr_t  awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  gb_timer_pkg::mmio_data_t  wdata,
    input  logic [0:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output gb_timer_pkg::axi_resp_t   bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  gb_timer_pkg::mmio_addr_t  araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output gb_timer_pkg::mmio_data_t  rdata,
    output gb_timer_pkg::axi_resp_t   rresp,
    output logic                      rvalid,
    input  logic                      rready,
    mmio_bus_if.controller            bus
);

    typedef enum logic [1:0] {
        s_idle,
        s_access,
        s_respond
    } state_t;

    state_t                   state;
    logic                     is_write;
    logic                     take_write;
    logic                     take_read;
    logic                     resp_done;
    gb_timer_pkg::mmio_addr_t addr_q;
    gb_timer_pkg::mmio_data_t wdata_q;
    logic                     strb_q;
    gb_timer_pkg::mmio_data_t rd_mux;
    gb_timer_pkg::mmio_data_t rdata_q;
    gb_timer_pkg::axi_resp_t  resp_q;

    // Write needs both address and data; it wins over a read in the same cycle
    assign take_write = (state == s_idle) && awvalid && wvalid;
    assign take_read  = (state == s_idle) && arvalid && !take_write;

    assign awready = take_write;
    assign wready  = take_write;
    assign arready = take_read;

    assign resp_done = is_write ? bready : rready;

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            state    <= s_idle;
            is_write <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (take_write) begin
                        state    <= s_access;
                        is_write <= 1'b1;
                    end else if (take_read) begin
                        state    <= s_access;
                        is_write <= 1'b0;
                    end
                end
                s_access: state <= s_respond;
                s_respond: begin
                    if (resp_done) begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Transaction payload
    always_ff @(posedge I_CLOCK) begin
        if (take_write) begin
            addr_q  <= awaddr;
            wdata_q <= wdata;
            strb_q  <= wstrb[0];
        end else if (take_read) begin
            addr_q <= araddr;
        end
    end

    // Pick whichever peripheral claims the address
    always_comb begin
        if (bus.hit_timer) begin
            rd_mux = bus.rdata_timer;
        end else if (bus.hit_irq) begin
            rd_mux = bus.rdata_irq;
        end else begin
            rd_mux = gb_timer_pkg::UNMAPPED_READ;
        end
    end

    // Response and read data sampled during the strobe cycle
    always_ff @(posedge I_CLOCK) begin
        if (state == s_access) begin
            resp_q <= (bus.hit_timer || bus.hit_irq) ? gb_timer_pkg::RESP_OKAY
                                                     : gb_timer_pkg::RESP_SLVERR;
            if (!is_write) begin
                rdata_q <= rd_mux;
            end
        end
    end

    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;
    assign bus.we    = (state == s_access) && is_write && strb_q;
    assign bus.re    = (state == s_access) && !is_write;

    assign bvalid = (state == s_respond) && is_write;
    assign rvalid = (state == s_respond) && !is_write;
    assign bresp  = resp_q;
    assign rresp  = resp_q;
    assign rdata  = rdata_q;

endmodule

`default_nettype wire

// File: div_timer.sv
// System counter with DIV, TIMA, TMA and TAC registers
// Tap edge detection and the TIMA overflow request
`timescale 1ns/1ns
`default_nettype none

module div_timer (
    input  logic             I_CLOCK,
    input  logic             I_RESET,
    mmio_bus_if.peripheral   bus,
    output logic             timer_req
);

    logic [15:0]              sys_cnt;
    gb_timer_pkg::mmio_data_t tima;
    gb_timer_pkg::mmio_data_t tma;
    logic [2:0]               tac;
    logic                     div_we;
    logic                     tima_we;
    logic                     tma_we;
    logic                     tac_we;
    logic                     tap;
    logic                     tima_clk;
    logic                     tima_clk_q;
    logic                     tima_inc;
    logic                     overflow;
    gb_timer_pkg::mmio_data_t reload;

    assign div_we  = bus.we && (bus.addr == gb_timer_pkg::ADDR_DIV);
    assign tima_we = bus.we && (bus.addr == gb_timer_pkg::ADDR_TIMA);
    assign tma_we  = bus.we && (bus.addr == gb_timer_pkg::ADDR_TMA);
    assign tac_we  = bus.we && (bus.addr == gb_timer_pkg::ADDR_TAC);

    // Tap selected by TAC[1:0]
    always_comb begin
        case (tac[1:0])
            2'd0:    tap = sys_cnt[9];
            2'd1:    tap = sys_cnt[3];
            2'd2:    tap = sys_cnt[5];
            default: tap = sys_cnt[7];
        endcase
    end

    assign tima_clk = tap & tac[2];

    // Falling edge against last cycle's value
    assign tima_inc = tima_clk_q & ~tima_clk;
    assign overflow = tima_inc && (tima == 8'hff);

    // A TMA write in the overflow cycle supplies the reload value
    assign reload = tma_we ? bus.wdata : tma;

    // No request when software overwrites TIMA in the same cycle
    assign timer_req = overflow && !tima_we;

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            sys_cnt    <= '0;
            tima_clk_q <= 1'b0;
            tima       <= '0;
            tma        <= '0;
            tac        <= '0;
        end else begin
            tima_clk_q <= tima_clk;

            if (div_we) begin
                sys_cnt <= '0;
            end else begin
                sys_cnt <= sys_cnt + 16'd1;
            end

            if (tima_we) begin
                tima <= bus.wdata;
            end else if (overflow) begin
                tima <= reload;
            end else if (tima_inc) begin
                tima <= tima + 8'd1;
            end

            if (tma_we) begin
                tma <= bus.wdata;
            end

            if (tac_we) begin
                tac <= bus.wdata[2:0];
            end
        end
    end

    // Read side decode for ff04 to ff07
    always_comb begin
        bus.hit_timer   = 1'b1;
        bus.rdata_timer = '0;
        case (bus.addr)
            gb_timer_pkg::ADDR_DIV:  bus.rdata_timer = sys_cnt[15:8];
            gb_timer_pkg::ADDR_TIMA: bus.rdata_timer = tima;
            gb_timer_pkg::ADDR_TMA:  bus.rdata_timer = tma;
            gb_timer_pkg::ADDR_TAC:  bus.rdata_timer = {5'd0, tac};
            default:                 bus.hit_timer   = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: gb_timer_pkg.sv
// Shared register-bus types, AXI response codes and the timer/interrupt address map
`default_nettype none

package gb_timer_pkg;

    // Register bus word types
    typedef logic [15:0] mmio_addr_t;
    typedef logic [7:0]  mmio_data_t;

    // AXI response codes
    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Timer block
    localparam mmio_addr_t ADDR_DIV  = 16'hff04;
    localparam mmio_addr_t ADDR_TIMA = 16'hff05;
    localparam mmio_addr_t ADDR_TMA  = 16'hff06;
    localparam mmio_addr_t ADDR_TAC  = 16'hff07;

    // Interrupt controller
    localparam mmio_addr_t ADDR_IF = 16'hff0f;
    localparam mmio_addr_t ADDR_IE = 16'hffff;

    // Request vector: 0 vblank, 1 lcd, 2 timer, 3 serial, 4 joypad
    typedef logic [4:0] irq_vec_t;

    localparam int IRQ_TIMER_BIT = 2;

    // Returned for reads that no peripheral claims
    localparam mmio_data_t UNMAPPED_READ = 8'hff;

endpackage

`default_nettype wire

// File: interrupt_ctrl.sv
// IF and IE registers, request capture and the CPU interrupt line
`timescale 1ns/1ns
`default_nettype none

module interrupt_ctrl (
    input  logic                    I_CLOCK,
    input  logic                    I_RESET,
    mmio_bus_if.peripheral          bus,
    input  logic                    timer_req,
    input  gb_timer_pkg::irq_vec_t  ext_req,
    output logic                    irq,
    output gb_timer_pkg::irq_vec_t  irq_pending
);

    gb_timer_pkg::irq_vec_t   if_q;
    gb_timer_pkg::mmio_data_t ie_q;
    gb_timer_pkg::irq_vec_t   req;
    logic                     if_we;
    logic                     ie_we;

    // Timer request replaces the unused external bit
    always_comb begin
        req                              = ext_req;
        req[gb_timer_pkg::IRQ_TIMER_BIT] = timer_req;
    end

    assign if_we = bus.we && (bus.addr == gb_timer_pkg::ADDR_IF);
    assign ie_we = bus.we && (bus.addr == gb_timer_pkg::ADDR_IE);

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            if_q <= '0;
            ie_q <= '0;
        end else begin
            // Acknowledge write never drops a request arriving that cycle
            if (if_we) begin
                if_q <= bus.wdata[4:0] | req;
            end else begin
                if_q <= if_q | req;
            end

            if (ie_we) begin
                ie_q <= bus.wdata;
            end
        end
    end

    assign irq_pending = if_q & ie_q[4:0];
    assign irq         = |irq_pending;

    // IF upper bits read back as ones
    assign bus.hit_irq   = (bus.addr == gb_timer_pkg::ADDR_IF) ||
                           (bus.addr == gb_timer_pkg::ADDR_IE);
    assign bus.rdata_irq = (bus.addr == gb_timer_pkg::ADDR_IF) ? {3'b111, if_q} : ie_q;

endmodule

`default_nettype wire

// File: mmio_bus_if.sv
// Byte-wide internal register bus between the AXI bridge and the peripherals
`timescale 1ns/1ns
`default_nettype none

interface mmio_bus_if;

    gb_timer_pkg::mmio_addr_t addr;
    gb_timer_pkg::mmio_data_t wdata;
    logic                     we;
    logic                     re;

    // Per-peripheral read data and address decode
    gb_timer_pkg::mmio_data_t rdata_timer;
    logic                     hit_timer;
    gb_timer_pkg::mmio_data_t rdata_irq;
    logic                     hit_irq;

    modport controller (
        output addr, wdata, we, re,
        input  rdata_timer, hit_timer, rdata_irq, hit_irq
    );

    // Each peripheral drives only its own rdata/hit pair
    modport peripheral (
        input  addr, wdata, we, re,
        output rdata_timer, hit_timer, rdata_irq, hit_irq
    );

endinterface

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the timer subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_timer_subsystem \
    -f verilog.f \
    -o sim_tb_timer_subsystem

./obj_dir/sim_tb_timer_subsystem

// File: tb_timer_subsystem.sv
// Testbench for the timer subsystem with random AXI4-Lite traffic
// Cycle model of counter, TIMA, TMA, TAC, IF and IE with compare tasks
`timescale 1ns/1ns
`default_nettype none

module tb_timer_subsystem;

    localparam int TXN_MAX     = 40;
    localparam int DIV_LEN     = 20 * (255 + 3 * TXN_MAX);
    localparam int TIMER_LEN   = TXN_MAX + 12 * (511 + 6 * TXN_MAX);
    localparam int IRQ_LEN     = 40 * (62 + 4 * TXN_MAX);
    localparam int UNMAP_LEN   = 20 * 2 * TXN_MAX;
    localparam int PAIR_LEN    = 30 * 2 * TXN_MAX;
    localparam int CYCLE_LIMIT = 2 * (10 + DIV_LEN + TIMER_LEN + IRQ_LEN + UNMAP_LEN + PAIR_LEN);

    logic                     I_CLOCK = 1'b0;
    logic                     I_RESET;
    gb_timer_pkg::mmio_addr_t awaddr;
    logic                     awvalid;
    logic                     awready;
    gb_timer_pkg::mmio_data_t wdata;
    logic [0:0]               wstrb;
    logic                     wvalid;
    logic                     wready;
    gb_timer_pkg::axi_resp_t  bresp;
    logic                     bvalid;
    logic                     bready;
    gb_timer_pkg::mmio_addr_t araddr;
    logic                     arvalid;
    logic                     arready;
    gb_timer_pkg::mmio_data_t rdata;
    gb_timer_pkg::axi_resp_t  rresp;
    logic                     rvalid;
    logic                     rready;
    gb_timer_pkg::irq_vec_t   ext_req = '0;
    logic                     irq;
    gb_timer_pkg::irq_vec_t   irq_pending;

    integer      seed = 32'hd12f;
    int          cycles = 0;
    logic        ext_en = 1'b0;
    logic [31:0] r;
    logic [31:0] r_ext;

    // Model state
    logic [15:0]              m_cnt;
    gb_timer_pkg::mmio_data_t m_tima;
    gb_timer_pkg::mmio_data_t m_tma;
    logic [2:0]               m_tac;
    logic                     m_clk_q;
    gb_timer_pkg::irq_vec_t   m_if;
    gb_timer_pkg::mmio_data_t m_ie;

    // Transaction tracking
    logic                     acc_valid;
    logic                     acc_wr;
    logic                     acc_strb;
    gb_timer_pkg::mmio_addr_t acc_addr;
    gb_timer_pkg::mmio_data_t acc_data;
    gb_timer_pkg::axi_resp_t  exp_resp;
    gb_timer_pkg::mmio_data_t exp_rdata;
    int                       wr_out;
    int                       rd_out;

    // Per-cycle update temporaries
    logic                     bus_idle;
    logic                     take_wr;
    logic                     take_rd;
    logic                     tap;
    logic                     tclk;
    logic                     inc;
    logic                     ovf;
    logic                     wr_en;
    gb_timer_pkg::irq_vec_t   req;

    timer_subsystem_top uut (
        .I_CLOCK     (I_CLOCK),
        .I_RESET     (I_RESET),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .ext_req     (ext_req),
        .irq         (irq),
        .irq_pending (irq_pending)
    );

    always #2 I_CLOCK = ~I_CLOCK;

    function automatic logic [31:0] rnd();
        rnd = $random(seed);
    endfunction

    function automatic logic mapped(input gb_timer_pkg::mmio_addr_t a);
        mapped = (a == gb_timer_pkg::ADDR_DIV) || (a == gb_timer_pkg::ADDR_TIMA) ||
                 (a == gb_timer_pkg::ADDR_TMA) || (a == gb_timer_pkg::ADDR_TAC) ||
                 (a == gb_timer_pkg::ADDR_IF) || (a == gb_timer_pkg::ADDR_IE);
    endfunction

    // Expected register value as seen by software
    function automatic gb_timer_pkg::mmio_data_t model_read(input gb_timer_pkg::mmio_addr_t a);
        case (a)
            gb_timer_pkg::ADDR_DIV:  model_read = m_cnt[15:8];
            gb_timer_pkg::ADDR_TIMA: model_read = m_tima;
            gb_timer_pkg::ADDR_TMA:  model_read = m_tma;
            gb_timer_pkg::ADDR_TAC:  model_read = {5'd0, m_tac};
            gb_timer_pkg::ADDR_IF:   model_read = {3'b111, m_if};
            gb_timer_pkg::ADDR_IE:   model_read = m_ie;
            default:                 model_read = 8'hff;
        endcase
    endfunction

    function automatic gb_timer_pkg::mmio_addr_t unmapped_addr(input logic [15:0] a);
        unmapped_addr = mapped(a) ? (a ^ 16'h0100) : a;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input gb_timer_pkg::mmio_data_t exp,
                              input gb_timer_pkg::mmio_data_t act);
        if (exp !== act) begin
            fail_run($sformatf("error at %0t: %s expected %h got %h", $time, name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input gb_timer_pkg::axi_resp_t exp,
                              input gb_timer_pkg::axi_resp_t act);
        if (exp !== act) begin
            fail_run($sformatf("error at %0t: %s expected %h got %h", $time, name, exp, act));
        end
    endtask

    task automatic check_vec(input string name, input gb_timer_pkg::irq_vec_t exp,
                             input gb_timer_pkg::irq_vec_t act);
        if (exp !== act) begin
            fail_run($sformatf("error at %0t: %s expected %h got %h", $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            fail_run($sformatf("error at %0t: %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    // Sparse external requests on all five bits, the timer bit is ignored by the DUT
    always @(posedge I_CLOCK) begin
        r_ext = rnd();
        if (ext_en) begin
            ext_req <= r_ext[4:0] & r_ext[12:8] & r_ext[20:16];
        end else begin
            ext_req <= '0;
        end
    end

    // Cycle model and response checks, all on pre-edge values
    always @(posedge I_CLOCK) begin
        if (I_RESET) begin
            m_cnt     = '0;
            m_tima    = '0;
            m_tma     = '0;
            m_tac     = '0;
            m_clk_q   = 1'b0;
            m_if      = '0;
            m_ie      = '0;
            acc_valid = 1'b0;
            wr_out    = 0;
            rd_out    = 0;
        end else begin
            cycles = cycles + 1;
            if (cycles > CYCLE_LIMIT) begin
                fail_run("timeout: the run did not finish within the cycle limit");
            end
            check_vec("irq_pending", m_if & m_ie[4:0], irq_pending);
            check_bit("irq", |(m_if & m_ie[4:0]), irq);

            // Accept only with nothing in flight and the write ahead of a read
            bus_idle = (wr_out == 0) && (rd_out == 0);
            take_wr  = bus_idle && awvalid && wvalid;
            take_rd  = bus_idle && arvalid && !(awvalid && wvalid);
            check_bit("awready", take_wr, awready);
            check_bit("wready", take_wr, wready);
            check_bit("arready", take_rd, arready);
            check_bit("bvalid", (wr_out != 0) && !acc_valid, bvalid);
            check_bit("rvalid", (rd_out != 0) && !acc_valid, rvalid);

            if (bvalid && bready) begin
                check_resp("bresp", exp_resp, bresp);
                wr_out = 0;
            end
            if (rvalid && rready) begin
                check_resp("rresp", exp_resp, rresp);
                check_data("rdata", exp_rdata, rdata);
                rd_out = 0;
            end

            // Strobe cycle of the accepted transaction
            wr_en = 1'b0;
            if (acc_valid) begin
                exp_resp = mapped(acc_addr) ? gb_timer_pkg::RESP_OKAY
                                            : gb_timer_pkg::RESP_SLVERR;
                if (!acc_wr) begin
                    exp_rdata = model_read(acc_addr);
                end
                wr_en = acc_wr && acc_strb;
            end

            case (m_tac[1:0])
                2'd0:    tap = m_cnt[9];
                2'd1:    tap = m_cnt[3];
                2'd2:    tap = m_cnt[5];
                default: tap = m_cnt[7];
            endcase
            tclk = tap & m_tac[2];
            inc  = m_clk_q & ~tclk;
            ovf  = inc && (m_tima == 8'hff);
            req  = ext_req;
            req[gb_timer_pkg::IRQ_TIMER_BIT] = ovf &&
                !(wr_en && acc_addr == gb_timer_pkg::ADDR_TIMA);

            m_clk_q = tclk;
            m_cnt   = (wr_en && acc_addr == gb_timer_pkg::ADDR_DIV) ? 16'd0 : m_cnt + 16'd1;
            if (wr_en && acc_addr == gb_timer_pkg::ADDR_TIMA) begin
                m_tima = acc_data;
            end else if (ovf) begin
                m_tima = (wr_en && acc_addr == gb_timer_pkg::ADDR_TMA) ? acc_data : m_tma;
            end else if (inc) begin
                m_tima = m_tima + 8'd1;
            end
            if (wr_en && acc_addr == gb_timer_pkg::ADDR_TMA) begin
                m_tma = acc_data;
            end
            if (wr_en && acc_addr == gb_timer_pkg::ADDR_TAC) begin
                m_tac = acc_data[2:0];
            end
            if (wr_en && acc_addr == gb_timer_pkg::ADDR_IF) begin
                m_if = acc_data[4:0] | req;
            end else begin
                m_if = m_if | req;
            end
            if (wr_en && acc_addr == gb_timer_pkg::ADDR_IE) begin
                m_ie = acc_data;
            end

            // Acceptance in this cycle gives the strobe next cycle
            acc_valid = 1'b0;
            if (take_wr || take_rd) begin
                acc_valid = 1'b1;
                acc_wr    = take_wr;
                acc_addr  = take_wr ? awaddr : araddr;
                acc_data  = wdata;
                acc_strb  = wstrb[0];
                if (take_wr) begin
                    wr_out = 1;
                end else begin
                    rd_out = 1;
                end
            end
        end
    end

    task automatic idle(input logic [9:0] n);
        repeat (n) @(posedge I_CLOCK);
    endtask

    // One write, one read, or both at once; returns when all responses are taken
    task automatic axi_txn(input logic do_wr, input logic do_rd,
                           input gb_timer_pkg::mmio_addr_t waddr,
                           input gb_timer_pkg::mmio_data_t wdat, input logic strb,
                           input gb_timer_pkg::mmio_addr_t raddr);
        logic        b_left;
        logic        r_left;
        logic [31:0] rr;
        b_left = do_wr;
        r_left = do_rd;
        @(posedge I_CLOCK);
        if (do_wr) begin
            awaddr  <= waddr;
            wdata   <= wdat;
            wstrb   <= strb;
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
        end
        if (do_rd) begin
            araddr  <= raddr;
            arvalid <= 1'b1;
        end
        while (b_left || r_left) begin
            @(posedge I_CLOCK);
            if (awvalid && awready) begin
                awvalid <= 1'b0;
                wvalid  <= 1'b0;
            end
            if (arvalid && arready) begin
                arvalid <= 1'b0;
            end
            if (bvalid && bready) begin
                b_left = 1'b0;
            end
            if (rvalid && rready) begin
                r_left = 1'b0;
            end
            rr = rnd();
            bready <= rr[1:0] != 2'b00;
            rready <= rr[3:2] != 2'b00;
        end
        bready <= 1'b0;
        rready <= 1'b0;
    endtask

    task automatic axi_write(input gb_timer_pkg::mmio_addr_t a,
                             input gb_timer_pkg::mmio_data_t d);
        axi_txn(1'b1, 1'b0, a, d, 1'b1, '0);
    endtask

    task automatic axi_read(input gb_timer_pkg::mmio_addr_t a);
        axi_txn(1'b0, 1'b1, '0, '0, 1'b0, a);
    endtask

    initial begin
        I_RESET = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (10) @(posedge I_CLOCK);
        I_RESET <= 1'b0;

        // DIV follows the counter and clears on any write
        for (int i = 0; i < 20; i++) begin
            r = rnd();
            idle(r[9:0] & 10'h0ff);
            axi_read(gb_timer_pkg::ADDR_DIV);
            if (r[13:12] == 2'b00) begin
                axi_write(gb_timer_pkg::ADDR_DIV, r[23:16]);
                axi_read(gb_timer_pkg::ADDR_DIV);
            end
        end

        // TIMA rate, reload and the timer request
        r = rnd();
        axi_write(gb_timer_pkg::ADDR_IE, r[7:0] | 8'h04);
        for (int i = 0; i < 12; i++) begin
            r = rnd();
            axi_write(gb_timer_pkg::ADDR_TAC, {5'd0, r[2] | r[3], r[1:0]});
            axi_write(gb_timer_pkg::ADDR_TMA, r[15:8]);
            axi_write(gb_timer_pkg::ADDR_TIMA, 8'hf0 | {4'd0, r[19:16]});
            idle(r[29:20] & 10'h1ff);
            axi_read(gb_timer_pkg::ADDR_TIMA);
            axi_read(gb_timer_pkg::ADDR_IF);
            axi_write(gb_timer_pkg::ADDR_IF, 8'h00);
        end

        // External requests against IE writes and IF acknowledges
        ext_en = 1'b1;
        for (int i = 0; i < 40; i++) begin
            r = rnd();
            idle(r[9:0] & 10'h01f);
            axi_write(gb_timer_pkg::ADDR_IE, r[17:10]);
            idle(r[29:20] & 10'h01f);
            axi_read(gb_timer_pkg::ADDR_IF);
            r = rnd();
            axi_write(gb_timer_pkg::ADDR_IF, r[7:0]);
            axi_read(gb_timer_pkg::ADDR_IE);
        end
        ext_en = 1'b0;

        // Unmapped addresses
        for (int i = 0; i < 20; i++) begin
            r = rnd();
            axi_write(unmapped_addr(r[15:0]), r[23:16]);
            axi_read(unmapped_addr(r[31:16]));
        end

        // Simultaneous write and read under back-pressure
        for (int i = 0; i < 30; i++) begin
            r = rnd();
            axi_txn(1'b1, 1'b1,
                    r[0] ? unmapped_addr(r[31:16]) : 16'hff04 + {13'd0, r[3:1] & 3'd3},
                    r[15:8], r[4] | r[5],
                    r[6] ? gb_timer_pkg::ADDR_IF : 16'hff04 + {14'd0, r[8:7]});
        end

        idle(10'd4);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: timer_subsystem_top.sv
// Top level of the timer and interrupt subsystem
// AXI4-Lite bridge, timer and interrupt controller on one register bus
`timescale 1ns/1ns
`default_nettype none

module timer_subsystem_top (
    input  logic                      I_CLOCK,
    input  logic                      I_RESET,
    input  gb_timer_pkg::mmio_addr_t  awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  gb_timer_pkg::mmio_data_t  wdata,
    input  logic [0:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output gb_timer_pkg::axi_resp_t   bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  gb_timer_pkg::mmio_addr_t  araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output gb_timer_pkg::mmio_data_t  rdata,
    output gb_timer_pkg::axi_resp_t   rresp,
    output logic                      rvalid,
    input  logic                      rready,
    input  gb_timer_pkg::irq_vec_t    ext_req,
    output logic                      irq,
    output gb_timer_pkg::irq_vec_t    irq_pending
);

    logic timer_req;

    mmio_bus_if bus ();

    axil_mmio_bridge u_bridge (
        .I_CLOCK (I_CLOCK),
        .I_RESET (I_RESET),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .bus     (bus.controller)
    );

    div_timer u_timer (
        .I_CLOCK   (I_CLOCK),
        .I_RESET   (I_RESET),
        .bus       (bus.peripheral),
        .timer_req (timer_req)
    );

    interrupt_ctrl u_irq (
        .I_CLOCK     (I_CLOCK),
        .I_RESET     (I_RESET),
        .bus         (bus.peripheral),
        .timer_req   (timer_req),
        .ext_req     (ext_req),
        .irq         (irq),
        .irq_pending (irq_pending)
    );

endmodule

`default_nettype wire

// File: verilog.f
gb_timer_pkg.sv
mmio_bus_if.sv
axil_mmio_bridge.sv
div_timer.sv
interrupt_ctrl.sv
timer_subsystem_top.sv
tb_timer_subsystem.sv
